//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_coh_tile_net
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_coh_tile_net.sv
// Testbench for the tile coherence network slice: LCG stimulus, expected queues, assertions
`timescale 1ns/1ps

module tb_coh_tile_net
  import coh_pkg::*;
();

  localparam int num_lce_c        = 2;
  localparam int timeout_cycles_c = 200;
  localparam int rr_msgs_c        = 12;
  localparam int solo_msgs_c      = 8;
  localparam int resp_msgs_c      = 12;
  localparam int cmd_msgs_c       = 16;

  logic                              clk_i = 1'b0;
  logic                              arst_n_i;
  coh_req_hdr_t  [num_lce_c-1:0]     lce_req_hdr_i;
  logic          [num_lce_c-1:0][31:0] lce_req_data_i;
  logic          [num_lce_c-1:0]     lce_req_v_i;
  logic          [num_lce_c-1:0]     lce_req_ready_and_o;
  coh_resp_hdr_t [num_lce_c-1:0]     lce_resp_hdr_i;
  logic          [num_lce_c-1:0][31:0] lce_resp_data_i;
  logic          [num_lce_c-1:0]     lce_resp_v_i;
  logic          [num_lce_c-1:0]     lce_resp_ready_and_o;
  coh_cmd_hdr_t  [num_lce_c-1:0]     lce_cmd_hdr_o;
  logic          [num_lce_c-1:0][31:0] lce_cmd_data_o;
  logic          [num_lce_c-1:0]     lce_cmd_v_o;
  logic          [num_lce_c-1:0]     lce_cmd_ready_and_i = '0;
  coh_flit_t                         req_link_data_o;
  logic                              req_link_v_o;
  logic                              req_link_ready_and_i = 1'b0;
  coh_flit_t                         resp_link_data_o;
  logic                              resp_link_v_o;
  logic                              resp_link_ready_and_i = 1'b0;
  coh_flit_t                         cmd_link_data_i;
  logic                              cmd_link_v_i;
  logic                              cmd_link_ready_and_o;

  logic [31:0] lcg_state    = 32'hc630;
  logic        stim_started = 1'b0;
  // Expected flits per LCE, path 0 is request and path 1 is response
  logic [39:0] req_q[2][$];
  logic [39:0] resp_q[2][$];
  // Command beats as {check data, header, data}
  logic [64:0] cmd_q[2][$];
  int          rr_ptr[2];
  int          cur_src[2];
  int          flits_left[2];

  coh_tile_net #(
    .num_lce_p(num_lce_c)
  ) i_dut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  function automatic int pending_flits(input int path, input int lce);
    if (path == 0) begin
      return req_q[lce].size();
    end
    return resp_q[lce].size();
  endfunction

  function automatic logic [39:0] pop_flit(input int path, input int lce);
    if (path == 0) begin
      return req_q[lce].pop_front();
    end
    return resp_q[lce].pop_front();
  endfunction

  task automatic push_flit(input int path, input int lce, input logic [39:0] flit);
    if (path == 0) begin
      req_q[lce].push_back(flit);
    end else begin
      resp_q[lce].push_back(flit);
    end
  endtask

  task automatic drive_stream(input int path, input int lce, input logic [31:0] hdr,
                              input logic [31:0] data, input logic v);
    if (path == 0) begin
      lce_req_hdr_i[lce]  = coh_req_hdr_t'(hdr);
      lce_req_data_i[lce] = data;
      lce_req_v_i[lce]    = v;
    end else begin
      lce_resp_hdr_i[lce]  = coh_resp_hdr_t'(hdr);
      lce_resp_data_i[lce] = data;
      lce_resp_v_i[lce]    = v;
    end
  endtask

  // Path 2 is the command link
  task automatic wait_ready(input int path, input int lce);
    int   cycles;
    logic ready;
    cycles = 0;
    ready  = 1'b0;
    while (!ready) begin
      @(posedge clk_i);
      case (path)
        0:       ready = lce_req_ready_and_o[lce];
        1:       ready = lce_resp_ready_and_o[lce];
        default: ready = cmd_link_ready_and_o;
      endcase
      cycles++;
      if (!ready && cycles >= timeout_cycles_c) begin
        $display("Timeout: no handshake on path %0d for LCE %0d", path, lce);
        stop_on_error();
      end
    end
  endtask

  task automatic send_stream(input int path, input int lce);
    logic [31:0] hdr;
    logic [31:0] words[4];
    logic [1:0]  size;
    int          beats;
    hdr   = lcg_next();
    size  = hdr[27:26];
    beats = (size == 2'd0) ? 1 : int'(size);
    for (int k = 0; k < 4; k++) begin
      words[k] = lcg_next();
    end
    // Header flit: CCE id as coordinate, child 0, len from size
    push_flit(path, lce, {hdr, 2'b00, size, 2'b00, hdr[29:28]});
    for (int k = 0; k < int'(size); k++) begin
      push_flit(path, lce, {words[k], 8'h00});
    end
    for (int b = 0; b < beats; b++) begin
      drive_stream(path, lce, hdr, words[b], 1'b1);
      wait_ready(path, lce);
      @(negedge clk_i);
    end
    drive_stream(path, lce, hdr, words[0], 1'b0);
  endtask

  task automatic send_cmd();
    logic [31:0] hdr;
    logic [31:0] r;
    logic [1:0]  size;
    int          lce;
    hdr  = lcg_next();
    r    = lcg_next();
    size = hdr[26:25];
    lce  = int'(r[5]);
    if (size == 2'd0) begin
      cmd_q[lce].push_back({1'b0, hdr, 32'h0});
    end
    // Coordinate bits are arbitrary here
    cmd_link_data_i = {hdr, 1'b0, r[5], size, r[3:0]};
    cmd_link_v_i    = 1'b1;
    wait_ready(2, lce);
    @(negedge clk_i);
    for (int k = 0; k < int'(size); k++) begin
      r = lcg_next();
      cmd_q[lce].push_back({1'b1, hdr, r});
      cmd_link_data_i = {r, 8'h00};
      wait_ready(2, lce);
      @(negedge clk_i);
    end
    cmd_link_v_i = 1'b0;
  endtask

  task automatic watch_link(input int path, input logic [39:0] flit);
    logic [39:0] exp;
    int          idx;
    string       name;
    if (path == 0) begin
      name = "req_link_data_o";
    end else begin
      name = "resp_link_data_o";
    end
    if (flits_left[path] == 0) begin
      // Round-robin: first LCE with a pending message at or after the pointer
      cur_src[path] = -1;
      for (int k = num_lce_c - 1; k >= 0; k--) begin
        idx = (rr_ptr[path] + k) % num_lce_c;
        if (pending_flits(path, idx) > 0) begin
          cur_src[path] = idx;
        end
      end
      if (cur_src[path] < 0) begin
        $display("Flit on %s at %0t with no message pending", name, $time);
        stop_on_error();
      end
    end
    exp = pop_flit(path, cur_src[path]);
    if (flits_left[path] == 0) begin
      flits_left[path] = int'(exp[5:4]) + 1;
    end
    flits_left[path]--;
    check_value(name, 64'(flit), 64'(exp));
    if (flits_left[path] == 0) begin
      rr_ptr[path] = (cur_src[path] + 1) % num_lce_c;
    end
  endtask

  task automatic watch_cmd(input int lce);
    logic [64:0] exp;
    if (cmd_q[lce].size() == 0) begin
      $display("Beat on lce_cmd output %0d at %0t with no command pending", lce, $time);
      stop_on_error();
    end
    exp = cmd_q[lce].pop_front();
    check_value($sformatf("lce_cmd_hdr_o[%0d]", lce), 64'(lce_cmd_hdr_o[lce]),
                64'(exp[63:32]));
    // Empty commands carry no data word
    if (exp[64]) begin
      check_value($sformatf("lce_cmd_data_o[%0d]", lce), 64'(lce_cmd_data_o[lce]),
                  64'(exp[31:0]));
    end
  endtask

  function automatic logic all_drained();
    logic empty;
    empty = 1'b1;
    for (int i = 0; i < num_lce_c; i++) begin
      empty = empty && req_q[i].size() == 0 && resp_q[i].size() == 0
              && cmd_q[i].size() == 0;
    end
    return empty;
  endfunction

  always @(negedge clk_i) begin
    logic [31:0] r;
    r = lcg_next();
    req_link_ready_and_i  = (r[1:0] != 2'b00);
    resp_link_ready_and_i = r[4];
    lce_cmd_ready_and_i   = r[9:8];
  end

  always @(posedge clk_i) begin
    if (!stim_started) begin
      assert (!req_link_v_o && !resp_link_v_o && lce_cmd_v_o == '0) else begin
        $display("Output valid high at %0t before any stimulus", $time);
        stop_on_error();
      end
    end
    if (req_link_v_o && req_link_ready_and_i) begin
      watch_link(0, req_link_data_o);
    end
    if (resp_link_v_o && resp_link_ready_and_i) begin
      watch_link(1, resp_link_data_o);
    end
    for (int i = 0; i < num_lce_c; i++) begin
      if (lce_cmd_v_o[i] && lce_cmd_ready_and_i[i]) begin
        watch_cmd(i);
      end
    end
  end

  initial begin
    int cycles;
    arst_n_i        = 1'b0;
    lce_req_hdr_i   = '0;
    lce_req_data_i  = '0;
    lce_req_v_i     = '0;
    lce_resp_hdr_i  = '0;
    lce_resp_data_i = '0;
    lce_resp_v_i    = '0;
    cmd_link_data_i = '0;
    cmd_link_v_i    = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    // A few idle cycles with reset released and nothing driven
    repeat (4) @(negedge clk_i);
    stim_started = 1'b1;
    fork
      repeat (rr_msgs_c) send_stream(0, 0);
      repeat (rr_msgs_c) send_stream(0, 1);
      repeat (resp_msgs_c) send_stream(1, 0);
      repeat (resp_msgs_c) send_stream(1, 1);
      repeat (cmd_msgs_c) send_cmd();
    join
    // LCE 0 alone on the request path
    repeat (solo_msgs_c) send_stream(0, 0);
    cycles = 0;
    while (!all_drained() && cycles < timeout_cycles_c) begin
      @(negedge clk_i);
      cycles++;
    end
    if (all_drained()) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Timeout: expected traffic never reached the outputs");
      stop_on_error();
    end
  end

endmodule

//--- hw/coh_concentrator_in.sv
// Many-to-one wormhole concentrator with packet-atomic round-robin arbitration
`timescale 1ns/1ps

module coh_concentrator_in
  import coh_pkg::*;
#(
  parameter int num_in_p = 2
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  coh_flit_t [num_in_p-1:0]   links_data_i,
  input  logic      [num_in_p-1:0]   links_v_i,
  output logic      [num_in_p-1:0]   links_ready_and_o,

  output coh_flit_t                  link_data_o,
  output logic                       link_v_o,
  input  logic                       link_ready_and_i
);

  localparam int sel_w = (num_in_p > 1) ? $clog2(num_in_p) : 1;

  logic [sel_w-1:0]           ptr_r;
  logic [sel_w-1:0]           grant_r;
  logic                       busy_r;
  logic [coh_len_width_c-1:0] cnt_r;
  logic [sel_w-1:0]           pick;
  logic                       any_v;
  logic [sel_w-1:0]           sel;
  logic [sel_w-1:0]           ptr_next;
  logic                       link_xfer;

  // First valid input at or after the pointer
  always_comb begin
    int idx;
    pick  = ptr_r;
    any_v = 1'b0;
    for (int k = num_in_p - 1; k >= 0; k--) begin
      idx = int'(ptr_r) + k;
      if (idx >= num_in_p) begin
        idx = idx - num_in_p;
      end
      if (links_v_i[idx]) begin
        any_v = 1'b1;
        pick  = sel_w'(idx);
      end
    end
  end

  assign sel         = busy_r ? grant_r : pick;
  assign link_v_o    = busy_r ? links_v_i[grant_r] : any_v;
  assign link_data_o = links_data_i[sel];
  assign link_xfer   = link_v_o & link_ready_and_i;

  always_comb begin
    links_ready_and_o = '0;
    links_ready_and_o[sel] = link_ready_and_i;
  end

  assign ptr_next = (sel == sel_w'(num_in_p - 1)) ? '0 : sel + 1'b1;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_r   <= '0;
      grant_r <= '0;
      busy_r  <= 1'b0;
      cnt_r   <= '0;
    end else if (link_xfer) begin
      if (!busy_r) begin
        if (link_data_o.len == '0) begin
          ptr_r <= ptr_next;
        end else begin
          busy_r  <= 1'b1;
          grant_r <= pick;
          cnt_r   <= link_data_o.len;
        end
      end else if (cnt_r == coh_len_width_c'(1)) begin
        busy_r <= 1'b0;
        ptr_r  <= ptr_next;
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

endmodule

//--- hw/coh_concentrator_out.sv
// One-to-many wormhole concentrator routing packets by child id
`timescale 1ns/1ps

module coh_concentrator_out
  import coh_pkg::*;
#(
  parameter int num_out_p = 2
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,

  input  coh_flit_t                  link_data_i,
  input  logic                       link_v_i,
  output logic                       link_ready_and_o,

  output coh_flit_t [num_out_p-1:0]  links_data_o,
  output logic      [num_out_p-1:0]  links_v_o,
  input  logic      [num_out_p-1:0]  links_ready_and_i
);

  logic                       busy_r;
  logic [coh_cid_width_c-1:0] route_r;
  logic [coh_len_width_c-1:0] cnt_r;
  logic [coh_cid_width_c-1:0] sel;
  logic                       link_xfer;

  // Header child id picks the route, held for the packet body
  assign sel = busy_r ? route_r : link_data_i.cid;

  always_comb begin
    link_ready_and_o = 1'b0;
    for (int i = 0; i < num_out_p; i++) begin
      links_data_o[i] = link_data_i;
      links_v_o[i]    = link_v_i & (sel == coh_cid_width_c'(i));
      if (sel == coh_cid_width_c'(i)) begin
        link_ready_and_o = links_ready_and_i[i];
      end
    end
  end

  assign link_xfer = link_v_i & link_ready_and_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r  <= 1'b0;
      route_r <= '0;
      cnt_r   <= '0;
    end else if (link_xfer) begin
      if (!busy_r) begin
        if (link_data_i.len != '0) begin
          busy_r  <= 1'b1;
          route_r <= link_data_i.cid;
          cnt_r   <= link_data_i.len;
        end
      end else if (cnt_r == coh_len_width_c'(1)) begin
        busy_r <= 1'b0;
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

endmodule

//--- hw/coh_pkg.sv
// Coherence network flit layout, LCE/CCE header structs and CCE id to coordinate mapping
package coh_pkg;

  localparam int coh_cord_width_c = 4;
  localparam int coh_len_width_c  = 2;
  localparam int coh_cid_width_c  = 2;
  localparam int coh_id_width_c   = 2;
  localparam int coh_data_width_c = 32;
  localparam int coh_flit_width_c = coh_data_width_c + coh_cid_width_c
                                    + coh_len_width_c + coh_cord_width_c;

  // Routing fields sit in the low byte, payload above
  typedef struct packed {
    logic [coh_data_width_c-1:0] payload;
    logic [coh_cid_width_c-1:0]  cid;
    logic [coh_len_width_c-1:0]  len;
    logic [coh_cord_width_c-1:0] cord;
  } coh_flit_t;

  typedef struct packed {
    logic [coh_cid_width_c-1:0]  cid;
    logic [coh_cord_width_c-1:0] cord;
  } coh_dst_t;

  typedef struct packed {
    logic [1:0]                msg_type;
    logic [coh_id_width_c-1:0] dst_id;
    logic [1:0]                size;
    logic [25:0]               addr;
  } coh_req_hdr_t;

  typedef struct packed {
    logic [1:0]                msg_type;
    logic [coh_id_width_c-1:0] dst_id;
    logic [1:0]                size;
    logic [2:0]                way;
    logic [22:0]               addr;
  } coh_resp_hdr_t;

  // dst_id is an LCE id here
  typedef struct packed {
    logic [2:0]                msg_type;
    logic [coh_id_width_c-1:0] dst_id;
    logic [1:0]                size;
    logic [24:0]               addr;
  } coh_cmd_hdr_t;

  // Single CCE column, every CCE sits at child 0 of its own coordinate
  function automatic coh_dst_t coh_cce_id_to_cord(logic [coh_id_width_c-1:0] cce_id);
    coh_dst_t dst;
    dst.cord = coh_cord_width_c'(cce_id);
    dst.cid  = '0;
    return dst;
  endfunction

endpackage

//--- hw/coh_stream_to_wormhole.sv
// Header-plus-data stream to wormhole packet packer
`timescale 1ns/1ps

module coh_stream_to_wormhole
  import coh_pkg::*;
#(
  parameter type hdr_t = coh_req_hdr_t
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  input  hdr_t                        pr_hdr_i,
  input  logic [coh_data_width_c-1:0] pr_data_i,
  input  logic                        pr_v_i,
  output logic                        pr_ready_and_o,

  output coh_flit_t                   link_data_o,
  output logic                        link_v_o,
  input  logic                        link_ready_and_i
);

  logic                       data_r;
  logic [coh_len_width_c-1:0] cnt_r;
  logic [coh_len_width_c-1:0] hdr_len;
  coh_dst_t                   dst;
  coh_flit_t                  hdr_flit;
  coh_flit_t                  data_flit;
  logic                       link_xfer;

  assign dst     = coh_cce_id_to_cord(pr_hdr_i.dst_id);
  assign hdr_len = coh_len_width_c'(pr_hdr_i.size);

  always_comb begin
    hdr_flit         = '0;
    hdr_flit.cord    = dst.cord;
    hdr_flit.cid     = dst.cid;
    hdr_flit.len     = hdr_len;
    hdr_flit.payload = pr_hdr_i;

    data_flit         = '0;
    data_flit.payload = pr_data_i;
  end

  assign link_v_o    = pr_v_i;
  assign link_data_o = data_r ? data_flit : hdr_flit;
  assign link_xfer   = link_v_o & link_ready_and_i;

  // Header flit only eats the beat of an empty message
  assign pr_ready_and_o = data_r ? link_ready_and_i
                                 : (link_ready_and_i & (hdr_len == '0));

  // cnt_r holds data flits still to send
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_r <= 1'b0;
      cnt_r  <= '0;
    end else if (link_xfer) begin
      if (!data_r) begin
        if (hdr_len != '0) begin
          data_r <= 1'b1;
          cnt_r  <= hdr_len;
        end
      end else if (cnt_r == coh_len_width_c'(1)) begin
        data_r <= 1'b0;
        cnt_r  <= '0;
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

endmodule

//--- hw/coh_tile_net.sv
// Tile coherence network slice: LCE request, response and command paths
`timescale 1ns/1ps

module coh_tile_net
  import coh_pkg::*;
#(
  parameter int num_lce_p = 2
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,

  input  coh_req_hdr_t  [num_lce_p-1:0]               lce_req_hdr_i,
  input  logic          [num_lce_p-1:0][coh_data_width_c-1:0] lce_req_data_i,
  input  logic          [num_lce_p-1:0]               lce_req_v_i,
  output logic          [num_lce_p-1:0]               lce_req_ready_and_o,

  input  coh_resp_hdr_t [num_lce_p-1:0]               lce_resp_hdr_i,
  input  logic          [num_lce_p-1:0][coh_data_width_c-1:0] lce_resp_data_i,
  input  logic          [num_lce_p-1:0]               lce_resp_v_i,
  output logic          [num_lce_p-1:0]               lce_resp_ready_and_o,

  output coh_cmd_hdr_t  [num_lce_p-1:0]               lce_cmd_hdr_o,
  output logic          [num_lce_p-1:0][coh_data_width_c-1:0] lce_cmd_data_o,
  output logic          [num_lce_p-1:0]               lce_cmd_v_o,
  input  logic          [num_lce_p-1:0]               lce_cmd_ready_and_i,

  output coh_flit_t                                   req_link_data_o,
  output logic                                        req_link_v_o,
  input  logic                                        req_link_ready_and_i,

  output coh_flit_t                                   resp_link_data_o,
  output logic                                        resp_link_v_o,
  input  logic                                        resp_link_ready_and_i,

  input  coh_flit_t                                   cmd_link_data_i,
  input  logic                                        cmd_link_v_i,
  output logic                                        cmd_link_ready_and_o
);

  // Per-LCE links before concentration
  coh_flit_t [num_lce_p-1:0] req_data;
  logic      [num_lce_p-1:0] req_v;
  logic      [num_lce_p-1:0] req_ready_and;

  coh_flit_t [num_lce_p-1:0] resp_data;
  logic      [num_lce_p-1:0] resp_v;
  logic      [num_lce_p-1:0] resp_ready_and;

  coh_flit_t [num_lce_p-1:0] cmd_data;
  logic      [num_lce_p-1:0] cmd_v;
  logic      [num_lce_p-1:0] cmd_ready_and;

  for (genvar i = 0; i < num_lce_p; i++) begin : g_lce
    coh_stream_to_wormhole #(
      .hdr_t(coh_req_hdr_t)
    ) i_req_pack (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .pr_hdr_i        (lce_req_hdr_i[i]),
      .pr_data_i       (lce_req_data_i[i]),
      .pr_v_i          (lce_req_v_i[i]),
      .pr_ready_and_o  (lce_req_ready_and_o[i]),
      .link_data_o     (req_data[i]),
      .link_v_o        (req_v[i]),
      .link_ready_and_i(req_ready_and[i])
    );

    coh_stream_to_wormhole #(
      .hdr_t(coh_resp_hdr_t)
    ) i_resp_pack (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .pr_hdr_i        (lce_resp_hdr_i[i]),
      .pr_data_i       (lce_resp_data_i[i]),
      .pr_v_i          (lce_resp_v_i[i]),
      .pr_ready_and_o  (lce_resp_ready_and_o[i]),
      .link_data_o     (resp_data[i]),
      .link_v_o        (resp_v[i]),
      .link_ready_and_i(resp_ready_and[i])
    );

    coh_wormhole_to_stream #(
      .hdr_t(coh_cmd_hdr_t)
    ) i_cmd_unpack (
      .clk_i           (clk_i),
      .arst_n_i        (arst_n_i),
      .link_data_i     (cmd_data[i]),
      .link_v_i        (cmd_v[i]),
      .link_ready_and_o(cmd_ready_and[i]),
      .pr_hdr_o        (lce_cmd_hdr_o[i]),
      .pr_data_o       (lce_cmd_data_o[i]),
      .pr_v_o          (lce_cmd_v_o[i]),
      .pr_ready_and_i  (lce_cmd_ready_and_i[i])
    );
  end

  coh_concentrator_in #(
    .num_in_p(num_lce_p)
  ) i_req_conc (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .links_data_i     (req_data),
    .links_v_i        (req_v),
    .links_ready_and_o(req_ready_and),
    .link_data_o      (req_link_data_o),
    .link_v_o         (req_link_v_o),
    .link_ready_and_i (req_link_ready_and_i)
  );

  coh_concentrator_in #(
    .num_in_p(num_lce_p)
  ) i_resp_conc (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .links_data_i     (resp_data),
    .links_v_i        (resp_v),
    .links_ready_and_o(resp_ready_and),
    .link_data_o      (resp_link_data_o),
    .link_v_o         (resp_link_v_o),
    .link_ready_and_i (resp_link_ready_and_i)
  );

  coh_concentrator_out #(
    .num_out_p(num_lce_p)
  ) i_cmd_conc (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .link_data_i      (cmd_link_data_i),
    .link_v_i         (cmd_link_v_i),
    .link_ready_and_o (cmd_link_ready_and_o),
    .links_data_o     (cmd_data),
    .links_v_o        (cmd_v),
    .links_ready_and_i(cmd_ready_and)
  );

endmodule

//--- hw/coh_wormhole_to_stream.sv
// Wormhole packet to header-plus-data stream unpacker
`timescale 1ns/1ps

module coh_wormhole_to_stream
  import coh_pkg::*;
#(
  parameter type hdr_t = coh_cmd_hdr_t
) (
  input  logic                        clk_i,
  input  logic                        arst_n_i,

  input  coh_flit_t                   link_data_i,
  input  logic                        link_v_i,
  output logic                        link_ready_and_o,

  output hdr_t                        pr_hdr_o,
  output logic [coh_data_width_c-1:0] pr_data_o,
  output logic                        pr_v_o,
  input  logic                        pr_ready_and_i
);

  logic                       hdr_v_r;
  logic [coh_len_width_c-1:0] cnt_r;
  hdr_t                       hdr_r;
  logic                       empty_msg;
  logic                       link_xfer;
  logic                       pr_xfer;

  // Header registered, no data flits behind it
  assign empty_msg = hdr_v_r & (cnt_r == '0);

  always_comb begin
    if (!hdr_v_r) begin
      link_ready_and_o = 1'b1;
      pr_v_o           = 1'b0;
    end else if (empty_msg) begin
      link_ready_and_o = 1'b0;
      pr_v_o           = 1'b1;
    end else begin
      link_ready_and_o = pr_ready_and_i;
      pr_v_o           = link_v_i;
    end
  end

  assign pr_hdr_o  = hdr_r;
  assign pr_data_o = link_data_i.payload;

  assign link_xfer = link_v_i & link_ready_and_o;
  assign pr_xfer   = pr_v_o & pr_ready_and_i;

  always_ff @(posedge clk_i) begin
    if (!hdr_v_r && link_xfer) begin
      hdr_r <= hdr_t'(link_data_i.payload);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hdr_v_r <= 1'b0;
      cnt_r   <= '0;
    end else if (!hdr_v_r) begin
      if (link_xfer) begin
        hdr_v_r <= 1'b1;
        cnt_r   <= link_data_i.len;
      end
    end else if (pr_xfer) begin
      if (empty_msg || cnt_r == coh_len_width_c'(1)) begin
        hdr_v_r <= 1'b0;
        cnt_r   <= '0;
      end else begin
        cnt_r <= cnt_r - 1'b1;
      end
    end
  end

endmodule

//--- project.f
hw/coh_pkg.sv
hw/coh_stream_to_wormhole.sv
hw/coh_wormhole_to_stream.sv
hw/coh_concentrator_in.sv
hw/coh_concentrator_out.sv
hw/coh_tile_net.sv
bench/tb_coh_tile_net.sv
